// ==== verilog/ialu_pkg.sv ====
// Shared widths, command codes and state encodings of the integer ALU.
// Every design file imports this package for its types.
`default_nettype none

package ialu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;   // Operand or result word
    typedef logic [4:0]      shamt_t;  // Shift amount
    typedef logic [4:0]      cnt_t;    // Multiply step counter

    // Multiply kind. Bit 1 marks op2 unsigned, any nonzero kind returns the high word
    typedef logic [1:0] mul_kind_t;

    localparam mul_kind_t KIND_MUL    = 2'b00;
    localparam mul_kind_t KIND_MULH   = 2'b01;
    localparam mul_kind_t KIND_MULHSU = 2'b10;
    localparam mul_kind_t KIND_MULHU  = 2'b11;

    // --------------------
    // Command codes
    typedef enum logic [4:0] {
        CMD_ADD    = 5'h00,
        CMD_SUB    = 5'h01,
        CMD_AND    = 5'h02,
        CMD_OR     = 5'h03,
        CMD_XOR    = 5'h04,
        CMD_SLT    = 5'h05,
        CMD_SLTU   = 5'h06,
        CMD_EQ     = 5'h07,
        CMD_NE     = 5'h08,
        CMD_GE     = 5'h09,
        CMD_GEU    = 5'h0a,
        CMD_SLL    = 5'h0b,
        CMD_SRL    = 5'h0c,
        CMD_SRA    = 5'h0d,
        CMD_MUL    = 5'h0e,
        CMD_MULH   = 5'h0f,
        CMD_MULHSU = 5'h10,
        CMD_MULHU  = 5'h11
    } ialu_cmd_e;

    typedef enum logic {
        FSM_IDLE = 1'b0,
        FSM_ITER = 1'b1
    } ialu_fsm_e;

endpackage

`default_nettype wire

// ==== verilog/ialu_mul_ctrl_if.sv ====
// Control bundle of the serial multiplier.
// Links the FSM, the step counter and the multiply datapath.
`default_nettype none

interface ialu_mul_ctrl_if;
    import ialu_pkg::*;

    logic      start;    // Load the first step
    logic      step;     // Advance one step in ITER
    logic      last;     // Final step of the operation
    logic      in_iter;  // FSM is in ITER
    mul_kind_t kind;     // Multiply kind from decode

    modport fsm (output start, output step, output in_iter, input last);

    modport counter (input start, input step, output last);

    modport datapath (input start, input step, input in_iter, input kind);

endinterface

`default_nettype wire

// ==== verilog/ialu_mul_fsm.sv ====
// IDLE/ITER control of the iterative multiply.
// Raises start and step for the counter and datapath and forms ialu_rdy.
`default_nettype none

module ialu_mul_fsm (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ialu_vd,
    input  logic            mul_req,
    ialu_mul_ctrl_if.fsm    ctrl,
    output logic            ialu_rdy
);
    import ialu_pkg::*;

    ialu_fsm_e state;
    ialu_fsm_e state_next;

    // --------------------
    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FSM_IDLE;
        end else if (!ialu_vd) begin
            state <= FSM_IDLE;  // Caller released the operation
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FSM_IDLE: begin
                if (mul_req) begin
                    state_next = FSM_ITER;
                end
            end
            FSM_ITER: begin
                if (ctrl.last) begin
                    state_next = FSM_IDLE;
                end
            end
            default: state_next = FSM_IDLE;
        endcase
    end

    // --------------------
    // Control outputs
    assign ctrl.in_iter = (state == FSM_ITER);
    assign ctrl.start   = (state == FSM_IDLE) & mul_req;  // First step happens in IDLE
    assign ctrl.step    = ctrl.in_iter & ialu_vd;

    // Busy only while a multiply is still being stepped
    assign ialu_rdy = ~(ctrl.start | (ctrl.in_iter & ~ctrl.last));

endmodule

`default_nettype wire

// ==== verilog/ialu_iter_counter.sv ====
// Down-counter of the remaining multiply steps.
// Loaded on start, decremented on step; last marks the final step.
`default_nettype none

module ialu_iter_counter #(
    parameter int MUL_STEP = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    ialu_mul_ctrl_if.counter    ctrl
);
    import ialu_pkg::*;

    // One step is taken in IDLE, the rest in ITER
    localparam cnt_t INIT_CNT = cnt_t'(XLEN / MUL_STEP - 2);

    cnt_t cnt_q;
    cnt_t cnt_dec;

    assign cnt_dec = cnt_q - cnt_t'(1);  // Own decrementer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (ctrl.start) begin
            cnt_q <= INIT_CNT;
        end else if (ctrl.step) begin
            cnt_q <= cnt_dec;
        end
    end

    assign ctrl.last = ctrl.step & (cnt_q == '0);

endmodule

`default_nettype wire

// ==== verilog/ialu_serial_mul.sv ====
// Shift-add multiplier handling MUL_STEP bits of op2 per cycle.
// The high accumulator and the low shift register update on start or step,
// and mul_hi/mul_lo show the updated value in the same cycle.
`default_nettype none

module ialu_serial_mul #(
    parameter int MUL_STEP = 1
) (
    input  logic                    clk,
    input  ialu_pkg::xlen_t         op1,
    input  ialu_pkg::xlen_t         op2,
    ialu_mul_ctrl_if.datapath       ctrl,
    output ialu_pkg::xlen_t         mul_hi,
    output ialu_pkg::xlen_t         mul_lo
);
    import ialu_pkg::*;

    localparam int PW = XLEN + 1 + MUL_STEP;  // Partial sum width

    xlen_t                   hi_q;      // High accumulator
    xlen_t                   lo_q;      // Low product bits above, op2 bits below
    xlen_t                   hi_d;
    xlen_t                   lo_d;
    xlen_t                   acc_base;
    xlen_t                   lo_src;
    xlen_t                   neg_fix;
    logic                    op1_signed;
    logic                    op2_signed;
    logic signed [XLEN:0]    op1_ext;
    logic signed [XLEN:0]    acc_ext;
    logic signed [MUL_STEP:0] chunk;
    logic signed [PW-1:0]    psum;

    // --------------------
    // Step arithmetic
    always_comb begin
        op1_signed = (ctrl.kind != KIND_MULHU);
        op2_signed = ~ctrl.kind[1];

        // First step starts from zero and the raw op2
        acc_base = ctrl.in_iter ? hi_q : '0;
        lo_src   = ctrl.in_iter ? lo_q : op2;

        op1_ext = {op1_signed & op1[XLEN-1], op1};
        acc_ext = {op1_signed & acc_base[XLEN-1], acc_base};
        chunk   = {1'b0, lo_src[MUL_STEP-1:0]};  // Chunk taken as unsigned

        psum = acc_ext + op1_ext * chunk;

        hi_d = psum[MUL_STEP +: XLEN];
        lo_d = {psum[MUL_STEP-1:0], lo_src[XLEN-1:MUL_STEP]};

        // Top bit of a signed op2 weighs -2^31, i.e. op1 less in the high word
        neg_fix = (op2_signed & op2[XLEN-1]) ? op1 : '0;
    end

    always_ff @(posedge clk) begin
        if (ctrl.start | ctrl.step) begin
            hi_q <= hi_d;
            lo_q <= lo_d;
        end
    end

    assign mul_hi = hi_d - neg_fix;
    assign mul_lo = lo_d;  // Low word is unaffected by the sign fix

endmodule

`default_nettype wire

// ==== verilog/ialu_adder_cmp.sv ====
// Main adder/subtractor with its flags and the compare outcomes.
// Purely combinational; sub selects op1 - op2.
`default_nettype none

module ialu_adder_cmp (
    input  ialu_pkg::xlen_t op1,
    input  ialu_pkg::xlen_t op2,
    input  logic            sub,
    output ialu_pkg::xlen_t sum,
    output logic            lt,
    output logic            ltu,
    output logic            eq
);
    import ialu_pkg::*;

    logic [XLEN:0] sum_full;  // Extra bit holds carry or borrow
    logic          flag_c;
    logic          flag_z;
    logic          flag_s;
    logic          flag_o;

    always_comb begin
        if (sub) begin
            sum_full = {1'b0, op1} - {1'b0, op2};
        end else begin
            sum_full = {1'b0, op1} + {1'b0, op2};
        end

        flag_c = sum_full[XLEN];
        flag_z = ~|sum_full[XLEN-1:0];
        flag_s = sum_full[XLEN-1];
        // Operand signs agree (after negation for sub) but result sign differs
        flag_o = ~(op1[XLEN-1] ^ op2[XLEN-1] ^ sub) & (op1[XLEN-1] ^ sum_full[XLEN-1]);
    end

    assign sum = sum_full[XLEN-1:0];
    assign lt  = flag_s ^ flag_o;
    assign ltu = flag_c;  // Borrow out of the subtraction
    assign eq  = flag_z;

endmodule

`default_nettype wire

// ==== verilog/ialu_logic_shift.sv ====
// Bitwise operations and barrel shifter, selected by the command.
// Combinational; SLL is the default for non-logic commands.
`default_nettype none

module ialu_logic_shift (
    input  ialu_pkg::xlen_t     op1,
    input  ialu_pkg::shamt_t    shamt,
    input  ialu_pkg::xlen_t     op2,
    input  ialu_pkg::ialu_cmd_e cmd,
    output ialu_pkg::xlen_t     res
);
    import ialu_pkg::*;

    always_comb begin
        case (cmd)
            CMD_AND: res = op1 & op2;
            CMD_OR:  res = op1 | op2;
            CMD_XOR: res = op1 ^ op2;
            CMD_SRL: res = op1 >> shamt;
            CMD_SRA: res = xlen_t'($signed(op1) >>> shamt);  // Sign fill
            default: res = op1 << shamt;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ialu_result_mux.sv ====
// Command decode and result selection of the ALU.
// Forms the adder mode, compare output, multiply kind and multiply request.
`default_nettype none

module ialu_result_mux (
    input  logic                ialu_vd,
    input  ialu_pkg::ialu_cmd_e ialu_cmd,
    input  ialu_pkg::xlen_t     op1,
    input  ialu_pkg::xlen_t     op2,
    input  ialu_pkg::xlen_t     sum,
    input  logic                lt,
    input  logic                ltu,
    input  logic                eq,
    input  ialu_pkg::xlen_t     logic_res,
    input  ialu_pkg::xlen_t     mul_hi,
    input  ialu_pkg::xlen_t     mul_lo,
    input  logic                in_iter,
    output ialu_pkg::xlen_t     ialu_res,
    output logic                ialu_cmp,
    output logic                sub,
    output logic                mul_req,
    output ialu_pkg::mul_kind_t kind
);
    import ialu_pkg::*;

    logic is_mul;
    logic is_cmp;
    logic ops_nz;
    logic cmp;

    assign ops_nz  = |op1 & |op2;
    assign sub     = (ialu_cmd != CMD_ADD);   // Compares reuse the subtractor
    assign mul_req = ialu_vd & is_mul & ops_nz;

    always_comb begin
        is_mul   = 1'b0;
        is_cmp   = 1'b0;
        cmp      = 1'b0;
        kind     = KIND_MUL;
        ialu_res = logic_res;
        case (ialu_cmd)
            CMD_ADD, CMD_SUB: ialu_res = sum;
            CMD_SLT:    {is_cmp, cmp} = {1'b1, lt};
            CMD_SLTU:   {is_cmp, cmp} = {1'b1, ltu};
            CMD_EQ:     {is_cmp, cmp} = {1'b1, eq};
            CMD_NE:     {is_cmp, cmp} = {1'b1, ~eq};
            CMD_GE:     {is_cmp, cmp} = {1'b1, ~lt};
            CMD_GEU:    {is_cmp, cmp} = {1'b1, ~ltu};
            CMD_MUL:    {is_mul, kind} = {1'b1, KIND_MUL};
            CMD_MULH:   {is_mul, kind} = {1'b1, KIND_MULH};
            CMD_MULHSU: {is_mul, kind} = {1'b1, KIND_MULHSU};
            CMD_MULHU:  {is_mul, kind} = {1'b1, KIND_MULHU};
            default: ;
        endcase

        if (is_cmp) begin
            ialu_res = xlen_t'(cmp);
        end else if (is_mul) begin
            // Only the ITER cycles carry a product; zero operands give 0
            if (ops_nz & in_iter) begin
                ialu_res = (kind != KIND_MUL) ? mul_hi : mul_lo;
            end else begin
                ialu_res = '0;
            end
        end
    end

    assign ialu_cmp = cmp;

endmodule

`default_nettype wire

// ==== verilog/ialu_top.sv ====
// Integer ALU of the execution stage with a serial multiplier.
// Caller holds ialu_vd and the operands until ialu_rdy is seen high.
// MUL_STEP sets the op2 bits handled per multiply cycle (1, 2 or 4).
`default_nettype none

module ialu_top #(
    parameter int MUL_STEP = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ialu_vd,
    input  ialu_pkg::ialu_cmd_e ialu_cmd,
    input  ialu_pkg::xlen_t     ialu_op1,
    input  ialu_pkg::xlen_t     ialu_op2,
    output ialu_pkg::xlen_t     ialu_res,
    output logic                ialu_cmp,
    output logic                ialu_rdy,
    output logic                ialu_busy
);
    import ialu_pkg::*;

    xlen_t sum;
    xlen_t logic_res;
    xlen_t mul_hi;
    xlen_t mul_lo;
    logic  sub;
    logic  lt;
    logic  ltu;
    logic  eq;
    logic  mul_req;

    ialu_mul_ctrl_if mul_ctrl ();

    // --------------------
    // Multiply control
    ialu_mul_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .ialu_vd  (ialu_vd),
        .mul_req  (mul_req),
        .ctrl     (mul_ctrl),
        .ialu_rdy (ialu_rdy)
    );

    ialu_iter_counter #(.MUL_STEP(MUL_STEP)) u_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (mul_ctrl)
    );

    ialu_serial_mul #(.MUL_STEP(MUL_STEP)) u_mul (
        .clk    (clk),
        .op1    (ialu_op1),
        .op2    (ialu_op2),
        .ctrl   (mul_ctrl),
        .mul_hi (mul_hi),
        .mul_lo (mul_lo)
    );

    // --------------------
    // Single-cycle datapath
    ialu_adder_cmp u_adder (
        .op1 (ialu_op1),
        .op2 (ialu_op2),
        .sub (sub),
        .sum (sum),
        .lt  (lt),
        .ltu (ltu),
        .eq  (eq)
    );

    ialu_logic_shift u_logic (
        .op1   (ialu_op1),
        .shamt (ialu_op2[$bits(shamt_t)-1:0]),  // Low bits only
        .op2   (ialu_op2),
        .cmd   (ialu_cmd),
        .res   (logic_res)
    );

    ialu_result_mux u_mux (
        .ialu_vd   (ialu_vd),
        .ialu_cmd  (ialu_cmd),
        .op1       (ialu_op1),
        .op2       (ialu_op2),
        .sum       (sum),
        .lt        (lt),
        .ltu       (ltu),
        .eq        (eq),
        .logic_res (logic_res),
        .mul_hi    (mul_hi),
        .mul_lo    (mul_lo),
        .in_iter   (mul_ctrl.in_iter),
        .ialu_res  (ialu_res),
        .ialu_cmp  (ialu_cmp),
        .sub       (sub),
        .mul_req   (mul_req),
        .kind      (mul_ctrl.kind)
    );

    assign ialu_busy = ialu_vd & ~ialu_rdy;

endmodule

`default_nettype wire

// ==== sim/ialu_fsm_checker.sv ====
// Concurrent checks on the multiply FSM, bound into ialu_mul_fsm.
// Failures raise $error and are counted for the testbench summary.
`default_nettype none

module ialu_fsm_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                ialu_vd,
    input logic                mul_req,
    input logic                last,
    input ialu_pkg::ialu_fsm_e state
);
    timeunit 1ns;
    timeprecision 100ps;
    import ialu_pkg::*;

    int assert_fails = 0;

    a_idle_to_iter: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FSM_IDLE && ialu_vd && mul_req) |=> state == FSM_ITER)
        else begin
            $error("FSM did not enter ITER on a multiply request");
            assert_fails++;
        end

    a_iter_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FSM_ITER && ialu_vd && !last) |=> state == FSM_ITER)
        else begin
            $error("FSM left ITER before the last step");
            assert_fails++;
        end

    a_iter_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == FSM_ITER && last) |=> state == FSM_IDLE)
        else begin
            $error("FSM did not return to IDLE after the last step");
            assert_fails++;
        end

    a_release: assert property (@(posedge clk) disable iff (!rst_n)
        !ialu_vd |=> state == FSM_IDLE)
        else begin
            $error("FSM not in IDLE after ialu_vd dropped");
            assert_fails++;
        end

    // mul_req folds in the command and both operands while ialu_vd is high
    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(ialu_vd) && (!ialu_vd || !$isunknown(mul_req)))
        else begin
            $error("Unknown value on ialu_vd, the command or the operands");
            assert_fails++;
        end

endmodule

bind ialu_mul_fsm ialu_fsm_checker u_fsm_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .ialu_vd (ialu_vd),
    .mul_req (mul_req),
    .last    (ctrl.last),
    .state   (state)
);

`default_nettype wire

// ==== sim/ialu_tb.sv ====
// Testbench of the integer ALU. Runs the vectors of sim/ialu_tests.txt,
// an early release of a multiply, then random multiplies of all four kinds
// against a 64-bit product model.
// Run from the project root so that the tests file is found.
`default_nettype none

module ialu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ialu_pkg::*;

    localparam int MUL_STEP   = 1;
    localparam int WAIT_LIMIT = 100;  // Cycles allowed for ialu_rdy
    localparam int N_RANDOM   = 40;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      ialu_vd;
    ialu_cmd_e ialu_cmd;
    xlen_t     ialu_op1;
    xlen_t     ialu_op2;
    xlen_t     ialu_res;
    logic      ialu_cmp;
    logic      ialu_rdy;
    logic      ialu_busy;

    int          value_errors = 0;
    int          timeouts     = 0;
    int          file_tests   = 0;
    logic [31:0] rng_state    = 32'd34292;
    ialu_cmd_e   mul_cmds[4]  = '{CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU};

    ialu_top #(.MUL_STEP(MUL_STEP)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ialu_vd   (ialu_vd),
        .ialu_cmd  (ialu_cmd),
        .ialu_op1  (ialu_op1),
        .ialu_op2  (ialu_op2),
        .ialu_res  (ialu_res),
        .ialu_cmp  (ialu_cmp),
        .ialu_rdy  (ialu_rdy),
        .ialu_busy (ialu_busy)
    );

    always #5 clk = ~clk;

    // --------------------
    // Compare tasks
    task automatic word_check(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %h expected %h (cmd %s)",
                     $time, name, got, exp, ialu_cmd.name());
            value_errors++;
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %b expected %b (cmd %s)",
                     $time, name, got, exp, ialu_cmd.name());
            value_errors++;
        end
    endtask

    task automatic cycle_check(input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t ns: ialu_rdy latency got %0d expected %0d (cmd %s)",
                     $time, got, exp, ialu_cmd.name());
            value_errors++;
        end
    endtask

    // --------------------
    // Reference model
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mul_kind_t kind_of(input ialu_cmd_e cmd);
        case (cmd)
            CMD_MULH:   return KIND_MULH;
            CMD_MULHSU: return KIND_MULHSU;
            CMD_MULHU:  return KIND_MULHU;
            default:    return KIND_MUL;
        endcase
    endfunction

    function automatic xlen_t mul_model(input mul_kind_t kind, input xlen_t a, input xlen_t b);
        logic [63:0] a_ext;
        logic [63:0] b_ext;
        logic [63:0] prod;
        a_ext = (kind != KIND_MULHU) ? {{32{a[31]}}, a} : {32'h0, a};
        b_ext = !kind[1] ? {{32{b[31]}}, b} : {32'h0, b};
        prod  = a_ext * b_ext;  // Low 64 bits of the extended product
        return (kind == KIND_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    // One operation with ialu_vd held until ialu_rdy is seen
    task automatic run_op(input ialu_cmd_e cmd, input xlen_t a, input xlen_t b,
                          input xlen_t exp_res, input logic exp_cmp);
        int   cycles;
        int   exp_cycles;
        logic seen;
        exp_cycles = 1;
        if ((cmd inside {CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU}) && a != 0 && b != 0) begin
            exp_cycles = XLEN / MUL_STEP;
        end
        @(posedge clk);
        ialu_vd  <= 1'b1;
        ialu_cmd <= cmd;
        ialu_op1 <= a;
        ialu_op2 <= b;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (ialu_rdy) begin
                seen = 1'b1;
            end else begin
                flag_check("ialu_busy", ialu_busy, 1'b1);
            end
        end
        if (!seen) begin
            $display("Timeout at %0t ns: ialu_rdy never came high within %0d cycles for %s",
                     $time, WAIT_LIMIT, cmd.name());
            timeouts++;
        end else begin
            word_check("ialu_res", ialu_res, exp_res);
            flag_check("ialu_cmp", ialu_cmp, exp_cmp);
            flag_check("ialu_busy", ialu_busy, 1'b0);
            cycle_check(cycles, exp_cycles);
        end
        @(posedge clk);
        ialu_vd <= 1'b0;  // Release before the next operation
    endtask

    // Multiply dropped part way, the unit must be idle one edge later
    task automatic release_early(input xlen_t a, input xlen_t b);
        @(posedge clk);
        ialu_vd  <= 1'b1;
        ialu_cmd <= CMD_MUL;
        ialu_op1 <= a;
        ialu_op2 <= b;
        repeat (5) begin
            @(negedge clk);
            flag_check("ialu_rdy", ialu_rdy, 1'b0);
        end
        @(posedge clk);
        ialu_vd <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        flag_check("ialu_rdy", ialu_rdy, 1'b1);
        flag_check("ialu_busy", ialu_busy, 1'b0);
    endtask

    // --------------------
    // Main sequence
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [4:0]  code;
        xlen_t       a;
        xlen_t       b;
        xlen_t       exp_res;
        logic        exp_cmp;
        ialu_cmd_e   cmd;
        int          assert_fails;

        $timeformat(-9, 0, "", 0);
        rst_n    = 1'b0;
        ialu_vd  = 1'b0;
        ialu_cmd = CMD_ADD;
        ialu_op1 = '0;
        ialu_op2 = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        flag_check("ialu_rdy", ialu_rdy, 1'b1);  // Idle after reset
        flag_check("ialu_busy", ialu_busy, 1'b0);

        fd = $fopen("sim/ialu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file sim/ialu_tests.txt");
            value_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h", code, a, b, exp_res, exp_cmp);
                if (n == 5) begin
                    run_op(ialu_cmd_e'(code), a, b, exp_res, exp_cmp);
                    file_tests++;
                end
            end
            $fclose(fd);
            if (file_tests == 0) begin
                $display("The tests file held no usable test lines");
                value_errors++;
            end
        end

        release_early(32'h0001_2345, 32'h0006_789a);

        for (int i = 0; i < N_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            a         = rng_state;
            rng_state = xorshift32(rng_state);
            b         = rng_state;
            cmd       = mul_cmds[i % 4];
            run_op(cmd, a, b, mul_model(kind_of(cmd), a, b), 1'b0);
        end

        assert_fails = u_dut.u_fsm.u_fsm_chk.assert_fails;
        $display("Done: %0d tests, %0d value errors, %0d timeouts, %0d assertion failures",
                 file_tests + N_RANDOM, value_errors, timeouts, assert_fails);
        if (value_errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ialu_tests.txt ====
# Columns, all hex: command code, op1, op2, expected ialu_res, expected ialu_cmp
# Codes: 00 ADD 01 SUB 02 AND 03 OR 04 XOR 05 SLT 06 SLTU 07 EQ 08 NE 09 GE 0a GEU
# 0b SLL 0c SRL 0d SRA 0e MUL 0f MULH 10 MULHSU 11 MULHU
00 00000005 00000007 0000000c 0
00 ffffffff 00000001 00000000 0
00 7fffffff 00000001 80000000 0
01 00000005 00000007 fffffffe 0
01 80000000 00000001 7fffffff 0
05 80000000 00000001 00000001 1
05 00000001 80000000 00000000 0
06 80000000 00000001 00000000 0
06 00000001 ffffffff 00000001 1
07 12345678 12345678 00000001 1
07 12345678 12345679 00000000 0
08 12345678 12345679 00000001 1
09 ffffffff 00000000 00000000 0
09 7fffffff 80000000 00000001 1
0a ffffffff 00000000 00000001 1
0a 00000000 00000001 00000000 0
02 f0f0ff00 ff00f0f0 f000f000 0
03 f0f0ff00 ff00f0f0 fff0fff0 0
04 f0f0ff00 ff00f0f0 0ff00ff0 0
0b 00000001 00000024 00000010 0
0c 80000000 0000001f 00000001 0
0d 80000000 0000001f ffffffff 0
0d 80000010 00000104 f8000001 0
0c 80000010 00000104 08000001 0
0e 00000000 12345678 00000000 0
11 ffffffff 00000000 00000000 0
0f 12345678 00000000 00000000 0
0e 00000007 00000006 0000002a 0
0e 80000000 ffffffff 80000000 0
0f ffffffff ffffffff 00000000 0
0f 80000000 80000000 40000000 0
0f 00000002 80000000 ffffffff 0
10 ffffffff ffffffff ffffffff 0
10 00000002 80000000 00000001 0
11 ffffffff ffffffff fffffffe 0

// ==== all.f ====
verilog/ialu_pkg.sv
verilog/ialu_mul_ctrl_if.sv
verilog/ialu_mul_fsm.sv
verilog/ialu_iter_counter.sv
verilog/ialu_serial_mul.sv
verilog/ialu_adder_cmp.sv
verilog/ialu_logic_shift.sv
verilog/ialu_result_mux.sv
verilog/ialu_top.sv
sim/ialu_fsm_checker.sv
sim/ialu_tb.sv

// ==== Bender.yml ====
package:
  name: ialu

sources:
  - files:
      - verilog/ialu_pkg.sv
      - verilog/ialu_mul_ctrl_if.sv
      - verilog/ialu_mul_fsm.sv
      - verilog/ialu_iter_counter.sv
      - verilog/ialu_serial_mul.sv
      - verilog/ialu_adder_cmp.sv
      - verilog/ialu_logic_shift.sv
      - verilog/ialu_result_mux.sv
      - verilog/ialu_top.sv
  - target: test
    files:
      - sim/ialu_fsm_checker.sv
      - sim/ialu_tb.sv
